//--- sim/l1_dcache_testdata.txt
# kind address write_data mask expected_data expected_fault, all hex
# memory word = address ^ c0de0000, IO reply = offset + 10000000, base 8000
RDMISS 00000104 00000000 f c0de0104 0
RDHIT 00000104 00000000 f c0de0104 0
RDHIT 00000138 00000000 f c0de0138 0
WRITE 00000104 11223344 3 11223344 0
RDHIT 00000104 00000000 f c0de3344 0
WRITE 00000200 aabbccdd c aabbccdd 0
RDMISS 00000200 00000000 f aabb0200 0
RDHIT 0000023c 00000000 f c0de023c 0
IORD 00008010 00000000 f 10000010 0
IORD 00008204 00000000 f 10000204 0
RDMISS 00000808 00000000 f 00000000 1
RDMISS 0000080c 00000000 f 00000000 1
FLUSH 00000000 00000000 0 00000000 0
RDMISS 00000104 00000000 f c0de3344 0
RDHIT 00000100 00000000 f c0de0100 0
RDMISS 00000200 00000000 f aabb0200 0

//--- all.f
+incdir+common
common/dcache_pkg.sv
hdl/ldst_request_decode.sv
dcache/dcache_line_array.sv
dcache/dcache_miss_controller.sv
hdl/ldst_response_merge.sv
hdl/l1_data_cache_top.sv
sim/data_memory_model.sv
sim/tb_l1_data_cache.sv

//--- sim/tb_l1_data_cache.sv
// L1 data cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_l1_data_cache;
	import dcache_pkg::*;

	localparam addr_t IO_BASE = 32'h0000_8000;
	localparam order_t WORD_ORDER = 2'h2;
	localparam int HIT_LATENCY = 2;
	localparam int WAIT_LIMIT = 200;
	localparam int REFUSE_CYCLES = 20;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic iosr_valid;
	addr_t iosr;
	logic ldst_req;
	ldst_req_t ldst_req_data;
	logic ldst_busy;
	logic ldst_valid;
	ldst_rsp_t ldst_rsp;
	logic mem_req;
	logic mem_lock;
	logic mem_rw;
	order_t mem_order;
	mask_t mem_mask;
	addr_t mem_addr;
	word_t mem_data;
	logic mem_valid;
	logic mem_fault;
	beat_t mem_beat;
	logic io_req;
	logic io_busy;
	logic io_rw;
	order_t io_order;
	addr_t io_addr;
	word_t io_data;
	logic io_valid;
	word_t io_rdata;

	int errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	l1_data_cache_top l1_data_cache_top_inst(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.iosr_valid(iosr_valid),
		.iosr(iosr),
		.ldst_req(ldst_req),
		.ldst_req_data(ldst_req_data),
		.ldst_busy(ldst_busy),
		.ldst_valid(ldst_valid),
		.ldst_rsp(ldst_rsp),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_rw(mem_rw),
		.mem_order(mem_order),
		.mem_mask(mem_mask),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_valid(mem_valid),
		.mem_fault(mem_fault),
		.mem_beat(mem_beat),
		.io_req(io_req),
		.io_busy(io_busy),
		.io_rw(io_rw),
		.io_order(io_order),
		.io_addr(io_addr),
		.io_data(io_data),
		.io_valid(io_valid),
		.io_rdata(io_rdata)
	);

	data_memory_model mem_model(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_rw(mem_rw),
		.mem_mask(mem_mask),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_valid(mem_valid),
		.mem_fault(mem_fault),
		.mem_beat(mem_beat),
		.io_req(io_req),
		.io_busy(io_busy),
		.io_addr(io_addr),
		.io_valid(io_valid),
		.io_rdata(io_rdata)
	);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#5 iCLOCK = ~iCLOCK;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_test(input string kind, input addr_t addr, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s %h: ok", tests_run, kind, addr);
		end else begin
			tests_failed++;
			$display("test %0d %s %h: mismatch", tests_run, kind, addr);
		end
	endtask

	// Busy is stable at the falling edge, so the next rising edge accepts
	task automatic wait_not_busy(output logic ok, output logic io_seen,
		output addr_t io_addr_seen, output logic io_rw_seen,
		output order_t io_order_seen, output word_t io_data_seen);
		int cycles;

		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			cycles++;
			if (!ldst_busy) begin
				ok = 1'b1;
			end
		end
		io_seen = io_req;
		io_addr_seen = io_addr;
		io_rw_seen = io_rw;
		io_order_seen = io_order;
		io_data_seen = io_data;
		@(posedge iCLOCK);
		ldst_req <= 1'b0;
	endtask

	task automatic wait_response(input logic exp_rw, output logic ok, output int cycles,
		output int mem_cycles);
		ok = 1'b0;
		cycles = 0;
		mem_cycles = 0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			cycles++;
			if (mem_req) begin
				mem_cycles++;
				if (mem_rw !== exp_rw) begin
					report_mismatch("mem_rw", mem_rw, exp_rw);
				end
				if (exp_rw && mem_order !== WORD_ORDER) begin
					report_mismatch("mem_order", mem_order, WORD_ORDER);
				end
			end
			if (ldst_valid) begin
				ok = 1'b1;
			end
		end
	endtask

	task automatic run_op(input string kind, input addr_t addr, input word_t data,
		input mask_t mask, input word_t exp_data, input logic exp_fault);
		int errors_before;
		logic ok;
		logic io_seen;
		addr_t io_addr_seen;
		logic io_rw_seen;
		order_t io_order_seen;
		word_t io_data_seen;
		int cycles;
		int mem_cycles;

		errors_before = errors;
		if (kind == "FLUSH") begin
			wait_not_busy(ok, io_seen, io_addr_seen, io_rw_seen, io_order_seen, io_data_seen);
			flush <= 1'b1;
			@(posedge iCLOCK);
			flush <= 1'b0;
			if (!ok) begin
				$display("Timeout: busy stayed high before the flush");
				timed_out = 1'b1;
				errors++;
			end
		end else if (kind == "RDMISS" || kind == "RDHIT" || kind == "WRITE" || kind == "IORD") begin
			@(posedge iCLOCK);
			ldst_req <= 1'b1;
			ldst_req_data <= '{rw: (kind == "WRITE"), order: WORD_ORDER, mask: mask,
				addr: addr, data: data};
			wait_not_busy(ok, io_seen, io_addr_seen, io_rw_seen, io_order_seen, io_data_seen);
			if (!ok) begin
				$display("Timeout: %s at %h was never accepted", kind, addr);
				timed_out = 1'b1;
				errors++;
			end else begin
				wait_response((kind == "WRITE"), ok, cycles, mem_cycles);
				if (!ok) begin
					$display("Timeout: %s at %h got no response", kind, addr);
					timed_out = 1'b1;
					errors++;
				end else begin
					if (ldst_rsp.page_fault !== exp_fault) begin
						report_mismatch("ldst_rsp.page_fault", ldst_rsp.page_fault, exp_fault);
					end
					// Data of a faulted read is undefined
					if (!exp_fault && ldst_rsp.data !== exp_data) begin
						report_mismatch("ldst_rsp.data", ldst_rsp.data, exp_data);
					end
					// Valid shows at the second falling edge after the accept edge
					if (kind == "RDHIT" && cycles != HIT_LATENCY) begin
						report_mismatch("read hit latency", cycles, HIT_LATENCY);
					end
					if (kind == "RDHIT" && mem_cycles != 0) begin
						$display("Read hit at %h went out to data memory", addr);
						errors++;
					end
					if (kind == "RDMISS" && mem_cycles == 0) begin
						$display("Read miss at %h made no data memory request", addr);
						errors++;
					end
					if (kind == "IORD") begin
						if (io_seen !== 1'b1) begin
							$display("IO read at %h did not raise io_req", addr);
							errors++;
						end else begin
							if (io_addr_seen !== addr - IO_BASE) begin
								report_mismatch("io_addr", io_addr_seen, addr - IO_BASE);
							end
							if (io_rw_seen !== 1'b0) begin
								report_mismatch("io_rw", io_rw_seen, 1'b0);
							end
							if (io_order_seen !== WORD_ORDER) begin
								report_mismatch("io_order", io_order_seen, WORD_ORDER);
							end
							if (io_data_seen !== data) begin
								report_mismatch("io_data", io_data_seen, data);
							end
						end
					end else if (io_seen !== 1'b0) begin
						$display("Cache access at %h raised io_req", addr);
						errors++;
					end
				end
			end
		end else begin
			$display("Unknown operation %s in the test data", kind);
			errors++;
		end
		report_test(kind, addr, errors_before);
	endtask

	initial begin
		int fd;
		int n;
		int errors_before;
		logic stop;
		string kind;
		logic [8*120-1:0] line_rest;
		addr_t addr;
		word_t data;
		mask_t mask;
		word_t exp_data;
		logic exp_fault;

		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		inRESET = 1'b0;
		flush = 1'b0;
		iosr_valid = 1'b0;
		iosr = '0;
		ldst_req = 1'b0;
		ldst_req_data = '0;
		repeat (16) @(posedge iCLOCK);
		inRESET <= 1'b1;

		// Without an IO base every request is refused
		errors_before = errors;
		@(posedge iCLOCK);
		ldst_req <= 1'b1;
		ldst_req_data <= '{rw: 1'b0, order: WORD_ORDER, mask: 4'hF, addr: 32'h104, data: '0};
		for (int i = 0; i < REFUSE_CYCLES; i++) begin
			@(negedge iCLOCK);
			if (ldst_busy !== 1'b1) begin
				report_mismatch("ldst_busy", ldst_busy, 1'b1);
			end
			if (mem_req !== 1'b0 || io_req !== 1'b0 || ldst_valid !== 1'b0) begin
				$display("A request was taken before the IO base was set");
				errors++;
			end
		end
		@(posedge iCLOCK);
		ldst_req <= 1'b0;
		report_test("NOBASE", 32'h104, errors_before);

		@(posedge iCLOCK);
		iosr_valid <= 1'b1;
		iosr <= IO_BASE;
		@(posedge iCLOCK);
		iosr_valid <= 1'b0;

		fd = $fopen("sim/l1_dcache_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
			errors++;
		end else begin
			stop = 1'b0;
			while (!stop) begin
				n = $fscanf(fd, "%s", kind);
				if (n != 1) begin
					stop = 1'b1;
				end else if (kind == "#") begin
					n = $fgets(line_rest, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h %h", addr, data, mask, exp_data, exp_fault);
					run_op(kind, addr, data, mask, exp_data, exp_fault);
					stop = timed_out;
				end
			end
			$fclose(fd);
		end

		$display("%0d tests, %0d with errors, %0d errors in total",
			tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/data_memory_model.sv
// Data memory and IO model
`timescale 1ns/1ps
`default_nettype none

module data_memory_model(
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_req,
	output logic mem_lock,
	input wire mem_rw,
	input wire dcache_pkg::mask_t mem_mask,
	input wire dcache_pkg::addr_t mem_addr,
	input wire dcache_pkg::word_t mem_data,
	output logic mem_valid,
	output logic mem_fault,
	output dcache_pkg::beat_t mem_beat,
	input wire io_req,
	output logic io_busy,
	input wire dcache_pkg::addr_t io_addr,
	output logic io_valid,
	output dcache_pkg::word_t io_rdata
);
	import dcache_pkg::*;

	localparam word_t FILL_KEY = 32'hC0DE_0000;
	localparam word_t IO_KEY = 32'h1000_0000;
	// Reads of this line always page-fault
	localparam addr_t FAULT_LINE = 32'h0000_0800;

	word_t mem [1024];
	integer seed;
	logic take;
	logic [9:0] widx;
	logic [8:0] bidx;

	initial begin
		seed = 95;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = addr_t'(i * 4) ^ FILL_KEY;
		end
	end

	assign take = mem_req && !mem_lock;
	assign widx = mem_addr[11:2];
	assign bidx = mem_addr[11:3];

	// One IO reply in flight at a time
	assign io_busy = io_valid;

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mem_lock <= 1'b0;
			mem_valid <= 1'b0;
			mem_fault <= 1'b0;
			io_valid <= 1'b0;
		end else begin
			mem_lock <= ($random(seed) & 3) == 0;
			mem_valid <= take;
			mem_fault <= take && !mem_rw && (mem_addr[31:6] == FAULT_LINE[31:6]);
			io_valid <= io_req;
		end
	end

	always @(posedge iCLOCK) begin
		if (take && mem_rw) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_mask[i]) begin
					mem[widx][i*8 +: 8] <= mem_data[i*8 +: 8];
				end
			end
		end
		if (take && !mem_rw) begin
			mem_beat <= {mem[{bidx, 1'b1}], mem[{bidx, 1'b0}]};
		end
		if (io_req) begin
			io_rdata <= io_addr + IO_KEY;
		end
	end

endmodule

`default_nettype wire

//--- hdl/l1_data_cache_top.sv
// L1 data cache top
`timescale 1ns/1ps
`default_nettype none

module l1_data_cache_top(
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire iosr_valid,
	input wire dcache_pkg::addr_t iosr,
	input wire ldst_req,
	input wire dcache_pkg::ldst_req_t ldst_req_data,
	output wire ldst_busy,
	output wire ldst_valid,
	output wire dcache_pkg::ldst_rsp_t ldst_rsp,
	output wire mem_req,
	input wire mem_lock,
	output wire mem_rw,
	output wire dcache_pkg::order_t mem_order,
	output wire dcache_pkg::mask_t mem_mask,
	output wire dcache_pkg::addr_t mem_addr,
	output wire dcache_pkg::word_t mem_data,
	input wire mem_valid,
	input wire mem_fault,
	input wire dcache_pkg::beat_t mem_beat,
	output wire io_req,
	input wire io_busy,
	output wire io_rw,
	output wire dcache_pkg::order_t io_order,
	output wire dcache_pkg::addr_t io_addr,
	output wire dcache_pkg::word_t io_data,
	input wire io_valid,
	input wire dcache_pkg::word_t io_rdata
);
	import dcache_pkg::*;

	logic cache_req;
	ldst_req_t cache_req_data;
	logic ctrl_idle;
	logic lookup_pending;
	logic lookup_valid;
	lookup_t lookup;
	logic lookup_is_read;
	logic fill_we;
	addr_t fill_addr;
	line_t fill_line;
	logic word_we;
	addr_t word_addr;
	mask_t word_mask;
	word_t word_data;
	logic done;
	ldst_rsp_t done_rsp;

	// Only a read hit lets the next request in behind a lookup
	assign lookup_pending = lookup_valid && !(lookup.hit && lookup_is_read);

	// Decode stage
	ldst_request_decode u_decode(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iosr_valid(iosr_valid),
		.iosr(iosr),
		.ldst_req(ldst_req),
		.ldst_req_data(ldst_req_data),
		.busy(ldst_busy),
		.mem_lock(mem_lock),
		.io_busy(io_busy),
		.ctrl_idle(ctrl_idle),
		.lookup_pending(lookup_pending),
		.cache_req(cache_req),
		.cache_req_data(cache_req_data),
		.io_req(io_req),
		.io_rw(io_rw),
		.io_order(io_order),
		.io_addr(io_addr),
		.io_data(io_data)
	);

	// Execute stage
	dcache_line_array u_line_array(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.cache_req(cache_req),
		.cache_req_data(cache_req_data),
		.lookup_valid(lookup_valid),
		.lookup(lookup),
		.fill_we(fill_we),
		.fill_addr(fill_addr),
		.fill_line(fill_line),
		.word_we(word_we),
		.word_addr(word_addr),
		.word_mask(word_mask),
		.word_data(word_data)
	);

	dcache_miss_controller u_miss_ctrl(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.cache_req(cache_req),
		.cache_req_data(cache_req_data),
		.lookup_valid(lookup_valid),
		.lookup(lookup),
		.idle(ctrl_idle),
		.lookup_is_read(lookup_is_read),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_rw(mem_rw),
		.mem_order(mem_order),
		.mem_mask(mem_mask),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_valid(mem_valid),
		.mem_fault(mem_fault),
		.mem_beat(mem_beat),
		.fill_we(fill_we),
		.fill_addr(fill_addr),
		.fill_line(fill_line),
		.word_we(word_we),
		.word_addr(word_addr),
		.word_mask(word_mask),
		.word_data(word_data),
		.done(done),
		.done_rsp(done_rsp)
	);

	// Result stage
	ldst_response_merge u_result(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lookup_valid(lookup_valid),
		.lookup(lookup),
		.lookup_is_read(lookup_is_read),
		.done(done),
		.done_rsp(done_rsp),
		.io_valid(io_valid),
		.io_data(io_rdata),
		.ldst_valid(ldst_valid),
		.ldst_rsp(ldst_rsp)
	);

endmodule

`default_nettype wire

//--- hdl/ldst_response_merge.sv
// Load/store response register
`timescale 1ns/1ps
`default_nettype none

module ldst_response_merge(
	input wire iCLOCK,
	input wire inRESET,
	input wire lookup_valid,
	input wire dcache_pkg::lookup_t lookup,
	input wire lookup_is_read,
	input wire done,
	input wire dcache_pkg::ldst_rsp_t done_rsp,
	input wire io_valid,
	input wire dcache_pkg::word_t io_data,
	output logic ldst_valid,
	output dcache_pkg::ldst_rsp_t ldst_rsp
);
	import dcache_pkg::*;

	logic hit_valid;
	logic next_valid;
	ldst_rsp_t next_rsp;

	assign hit_valid = lookup_valid && lookup.hit && lookup_is_read;

	// IO first, then miss/store completion, then read hit
	always_comb begin
		next_valid = 1'b1;
		if (io_valid) begin
			next_rsp = '{data: io_data, page_fault: 1'b0};
		end else if (done) begin
			next_rsp = done_rsp;
		end else begin
			next_valid = hit_valid;
			next_rsp = '{data: lookup.word, page_fault: 1'b0};
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ldst_valid <= 1'b0;
		end else begin
			ldst_valid <= next_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (next_valid) begin
			ldst_rsp <= next_rsp;
		end
	end

endmodule

`default_nettype wire

//--- dcache/dcache_miss_controller.sv
// Line fill and write-through control
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_miss_controller(
	input wire iCLOCK,
	input wire inRESET,
	input wire cache_req,
	input wire dcache_pkg::ldst_req_t cache_req_data,
	input wire lookup_valid,
	input wire dcache_pkg::lookup_t lookup,
	output logic idle,
	output logic lookup_is_read,
	output logic mem_req,
	input wire mem_lock,
	output logic mem_rw,
	output dcache_pkg::order_t mem_order,
	output dcache_pkg::mask_t mem_mask,
	output dcache_pkg::addr_t mem_addr,
	output dcache_pkg::word_t mem_data,
	input wire mem_valid,
	input wire mem_fault,
	input wire dcache_pkg::beat_t mem_beat,
	output logic fill_we,
	output dcache_pkg::addr_t fill_addr,
	output dcache_pkg::line_t fill_line,
	output logic word_we,
	output dcache_pkg::addr_t word_addr,
	output dcache_pkg::mask_t word_mask,
	output dcache_pkg::word_t word_data,
	output logic done,
	output dcache_pkg::ldst_rsp_t done_rsp
);
	import dcache_pkg::*;

	miss_state_t state;
	ldst_req_t req;
	logic [`DCACHE_BEAT_IDX_W-1:0] req_cnt;
	logic [`DCACHE_BEAT_IDX_W-1:0] get_cnt;
	line_t line_buf;
	word_t rsp_word;
	logic fault;
	logic beat_in;

	assign beat_in = mem_valid && (state == MEMREQ || state == MEMGET);

	always_ff @(posedge iCLOCK) begin
		if (cache_req) begin
			req <= cache_req_data;
		end
	end

	// Beats arrive lowest first and shift down into the line
	always_ff @(posedge iCLOCK) begin
		if (beat_in) begin
			line_buf <= {mem_beat, line_buf[`DCACHE_LINE_W-1:`DCACHE_BEAT_W]};
			if (get_cnt == req.addr[`DCACHE_OFFSET_W-1 -: `DCACHE_BEAT_IDX_W]) begin
				rsp_word <= req.addr[2] ? mem_beat[`DCACHE_BEAT_W-1 -: `DCACHE_WORD_W] :
					mem_beat[`DCACHE_WORD_W-1:0];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			req_cnt <= '0;
			get_cnt <= '0;
			fault <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					req_cnt <= '0;
					get_cnt <= '0;
					if (lookup_valid) begin
						fault <= 1'b0;
						if (req.rw) begin
							state <= WR_MEMREQ;
						end else if (!lookup.hit) begin
							state <= MEMREQ;
						end
					end
				end
				MEMREQ: begin
					// Early beats may come back while requests are still going out
					if (beat_in) begin
						get_cnt <= get_cnt + 1'b1;
					end
					if (beat_in && mem_fault) begin
						fault <= 1'b1;
						state <= OUTDATA;
					end else if (!mem_lock) begin
						req_cnt <= req_cnt + 1'b1;
						if (req_cnt == `DCACHE_BEATS - 1) begin
							state <= MEMGET;
						end
					end
				end
				MEMGET: begin
					if (beat_in) begin
						get_cnt <= get_cnt + 1'b1;
						if (mem_fault) begin
							fault <= 1'b1;
							state <= OUTDATA;
						end else if (get_cnt == `DCACHE_BEATS - 1) begin
							state <= OUTDATA;
						end
					end
				end
				OUTDATA: state <= IDLE;
				WR_MEMREQ: begin
					if (!mem_lock) begin
						state <= WR_MEMGET;
					end
				end
				WR_MEMGET: begin
					if (mem_valid) begin
						fault <= mem_fault;
						state <= WR_OUTDATA;
					end
				end
				WR_OUTDATA: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign idle = state == IDLE;
	assign lookup_is_read = !req.rw;

	// Data memory port
	assign mem_req = state == MEMREQ || state == WR_MEMREQ;
	assign mem_rw = state == WR_MEMREQ;
	assign mem_order = req.order;
	assign mem_mask = req.mask;
	assign mem_addr = mem_rw ? req.addr :
		{req.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], req_cnt, 3'b000};
	assign mem_data = req.data;

	// A faulted fill leaves the line untouched
	assign fill_we = state == OUTDATA && !fault;
	assign fill_addr = req.addr;
	assign fill_line = line_buf;

	assign word_we = state == WR_MEMREQ && !mem_lock;
	assign word_addr = req.addr;
	assign word_mask = req.mask;
	assign word_data = req.data;

	assign done = state == OUTDATA || state == WR_OUTDATA;
	assign done_rsp = '{data: (state == WR_OUTDATA) ? req.data : rsp_word, page_fault: fault};

endmodule

`default_nettype wire

//--- dcache/dcache_line_array.sv
// Direct-mapped line storage
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_line_array(
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire cache_req,
	input wire dcache_pkg::ldst_req_t cache_req_data,
	output logic lookup_valid,
	output dcache_pkg::lookup_t lookup,
	input wire fill_we,
	input wire dcache_pkg::addr_t fill_addr,
	input wire dcache_pkg::line_t fill_line,
	input wire word_we,
	input wire dcache_pkg::addr_t word_addr,
	input wire dcache_pkg::mask_t word_mask,
	input wire dcache_pkg::word_t word_data
);
	import dcache_pkg::*;

	logic [`DCACHE_TAG_W-1:0] tag_mem [`DCACHE_LINES];
	line_t data_mem [`DCACHE_LINES];
	logic [`DCACHE_LINES-1:0] valid_bits;

	logic [`DCACHE_INDEX_W-1:0] req_idx;
	logic [`DCACHE_INDEX_W-1:0] fill_idx;
	logic [`DCACHE_INDEX_W-1:0] word_idx;
	logic [`DCACHE_TAG_W-1:0] req_tag;
	logic [`DCACHE_TAG_W-1:0] word_tag;
	logic [`DCACHE_OFFSET_W-3:0] req_sel;
	logic [`DCACHE_OFFSET_W-3:0] word_sel;
	logic word_hit;

	// Tag | index | byte offset
	assign req_idx = cache_req_data.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
	assign req_tag = cache_req_data.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	assign req_sel = cache_req_data.addr[`DCACHE_OFFSET_W-1:2];
	assign fill_idx = fill_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
	assign word_idx = word_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
	assign word_tag = word_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	assign word_sel = word_addr[`DCACHE_OFFSET_W-1:2];

	// Store only touches a line that is present
	assign word_hit = word_we && valid_bits[word_idx] && (tag_mem[word_idx] == word_tag);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_bits <= '0;
			lookup_valid <= 1'b0;
		end else begin
			lookup_valid <= cache_req;
			// Flush wins over a fill in the same cycle
			if (flush) begin
				valid_bits <= '0;
			end else if (fill_we) begin
				valid_bits[fill_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (cache_req) begin
			lookup.hit <= valid_bits[req_idx] && (tag_mem[req_idx] == req_tag);
			lookup.word <= data_mem[req_idx][req_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];
		end
		if (fill_we) begin
			tag_mem[fill_idx] <= fill_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
			data_mem[fill_idx] <= fill_line;
		end else if (word_hit) begin
			// Byte lanes under the mask
			for (int i = 0; i < 4; i++) begin
				if (word_mask[i]) begin
					data_mem[word_idx][word_sel*`DCACHE_WORD_W + i*8 +: 8] <= word_data[i*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ldst_request_decode.sv
// Load/store request decode
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module ldst_request_decode(
	input wire iCLOCK,
	input wire inRESET,
	input wire iosr_valid,
	input wire dcache_pkg::addr_t iosr,
	input wire ldst_req,
	input wire dcache_pkg::ldst_req_t ldst_req_data,
	output logic busy,
	input wire mem_lock,
	input wire io_busy,
	input wire ctrl_idle,
	input wire lookup_pending,
	output logic cache_req,
	output dcache_pkg::ldst_req_t cache_req_data,
	output logic io_req,
	output logic io_rw,
	output dcache_pkg::order_t io_order,
	output dcache_pkg::addr_t io_addr,
	output dcache_pkg::word_t io_data
);
	import dcache_pkg::*;

	logic io_base_valid;
	addr_t io_base;
	logic accept;
	logic is_io;

	// IO start address is taken once from the system info bus
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			io_base_valid <= 1'b0;
		end else if (iosr_valid) begin
			io_base_valid <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (iosr_valid && !io_base_valid) begin
			io_base <= iosr;
		end
	end

	assign busy = !io_base_valid || mem_lock || io_busy || !ctrl_idle || lookup_pending;
	assign accept = ldst_req && !busy;

	// Everything from the IO base upward belongs to the IO space
	assign is_io = ldst_req_data.addr >= io_base;

	assign cache_req = accept && !is_io;
	assign cache_req_data = ldst_req_data;

	assign io_req = accept && is_io;
	assign io_rw = ldst_req_data.rw;
	assign io_order = `DCACHE_IO_ORDER;
	assign io_addr = ldst_req_data.addr - io_base;
	assign io_data = ldst_req_data.data;

endmodule

`default_nettype wire

//--- common/dcache_pkg.sv
// L1 data cache types
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

	typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
	typedef logic [`DCACHE_WORD_W-1:0] word_t;
	typedef logic [`DCACHE_BEAT_W-1:0] beat_t;
	typedef logic [`DCACHE_LINE_W-1:0] line_t;
	typedef logic [3:0] mask_t;
	typedef logic [1:0] order_t;

	// Load/store request
	typedef struct packed {
		// High for a store
		logic rw;
		order_t order;
		mask_t mask;
		addr_t addr;
		word_t data;
	} ldst_req_t;

	typedef struct packed {
		word_t data;
		logic page_fault;
	} ldst_rsp_t;

	// Registered result of a tag lookup
	typedef struct packed {
		logic hit;
		word_t word;
	} lookup_t;

	typedef enum logic [2:0] {
		IDLE,
		MEMREQ,
		MEMGET,
		OUTDATA,
		WR_MEMREQ,
		WR_MEMGET,
		WR_OUTDATA
	} miss_state_t;

endpackage

`default_nettype wire

//--- common/dcache_defines.svh
// L1 data cache geometry
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Bus widths
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32
`define DCACHE_BEAT_W 64

// 16 lines of 64 bytes, filled as eight beats
`define DCACHE_LINES 16
`define DCACHE_BEATS 8
`define DCACHE_BEAT_IDX_W 3
`define DCACHE_INDEX_W 4
`define DCACHE_OFFSET_W 6
`define DCACHE_TAG_W (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)
`define DCACHE_LINE_W (`DCACHE_BEAT_W * `DCACHE_BEATS)

// IO accesses are always word sized
`define DCACHE_IO_ORDER 2'h2

`endif
